// File: logic/prbs_defines.svh
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// LFSR order, any value from 2 up to the channel count
`define PRBS_ORDER 7

// bits per word, bit 0 is oldest in stream order
`define PRBS_CHANNELS 16

// APB byte addresses
`define REG_CTRL     8'h00
`define REG_EQN      8'h04
`define REG_CHAN_SEL 8'h08
`define REG_SEED     8'h0C
`define REG_ERR_LO   8'h10
`define REG_ERR_HI   8'h14
`define REG_TOT_LO   8'h18
`define REG_TOT_HI   8'h1C

`endif

// File: logic/prbs_pkg.sv
`default_nettype none

`include "prbs_defines.svh"

package prbs_pkg;

    // checker mode, encoding 3 is illegal
    typedef enum logic [1:0] {
        CHK_CLEAR  = 2'd0,
        CHK_RUN    = 2'd1,
        CHK_FREEZE = 2'd2
    } chk_mode_e;

    // one received or transmitted word
    typedef logic [`PRBS_CHANNELS-1:0] prbs_word_t;

    // tap equation and generator seed / state
    typedef logic [`PRBS_ORDER-1:0] prbs_state_t;

    // bit counters
    typedef logic [63:0] count_t;

endpackage

`default_nettype wire

// File: logic/prbs_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defines.svh"

module prbs_apb_regs
    import prbs_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    input  wire count_t      err_count,
    input  wire count_t      total_count,
    output chk_mode_e        mode,
    output prbs_state_t      eqn,
    output prbs_state_t      seed,
    output prbs_word_t       chan_sel,
    output logic             rx_invert,
    output logic             tx_invert,
    output logic             gen_en,
    output logic             seed_load
);

    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_data;

    // zero wait states, every access finishes in its access phase
    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode      <= CHK_CLEAR;
            eqn       <= '0;
            seed      <= '0;
            chan_sel  <= '0;
            rx_invert <= 1'b0;
            tx_invert <= 1'b0;
            gen_en    <= 1'b0;
            seed_load <= 1'b0;
        end else begin
            seed_load <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    `REG_CTRL: begin
                        // mode 3 would be illegal, drop the whole write
                        if (pwdata[1:0] != 2'b11) begin
                            mode      <= chk_mode_e'(pwdata[1:0]);
                            rx_invert <= pwdata[2];
                            tx_invert <= pwdata[3];
                            gen_en    <= pwdata[4];
                        end
                    end
                    `REG_EQN: begin
                        eqn <= pwdata[`PRBS_ORDER-1:0];
                    end
                    `REG_CHAN_SEL: begin
                        chan_sel <= pwdata[`PRBS_CHANNELS-1:0];
                    end
                    `REG_SEED: begin
                        seed      <= pwdata[`PRBS_ORDER-1:0];
                        seed_load <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, counter halves are read only
    always_comb begin
        rd_data = '0;
        case (paddr)
            `REG_CTRL:     rd_data = {27'd0, gen_en, tx_invert, rx_invert, mode};
            `REG_EQN:      rd_data = 32'(eqn);
            `REG_CHAN_SEL: rd_data = 32'(chan_sel);
            `REG_SEED:     rd_data = 32'(seed);
            `REG_ERR_LO:   rd_data = err_count[31:0];
            `REG_ERR_HI:   rd_data = err_count[63:32];
            `REG_TOT_LO:   rd_data = total_count[31:0];
            `REG_TOT_HI:   rd_data = total_count[63:32];
            default:       rd_data = '0;
        endcase
    end

    assign prdata = rd_en ? rd_data : '0;

    // master must hold address and data from setup into access
    a_apb_stable: assert property (
        @(posedge clk) disable iff (rst)
        (psel && !penable) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    ) else $error("APB signals changed between setup and access phase");

endmodule

`default_nettype wire

// File: logic/prbs_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defines.svh"

module prbs_generator
    import prbs_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        gen_en,
    input  wire logic        seed_load,
    input  wire logic        tx_invert,
    input  wire prbs_state_t seed,
    input  wire prbs_state_t eqn,
    output prbs_word_t       tx_bits
);

    // bit 0 of the state is the most recent stream bit
    prbs_state_t state;
    prbs_state_t next_state;
    prbs_word_t  next_word;

    // unroll the recurrence once per channel
    always_comb begin
        logic        new_bit;
        prbs_state_t hist;
        hist = state;
        for (int i = 0; i < `PRBS_CHANNELS; i++) begin
            new_bit      = ^(hist & eqn);
            next_word[i] = new_bit;
            hist         = {hist[`PRBS_ORDER-2:0], new_bit};
        end
        next_state = hist;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= '0;
            tx_bits <= '0;
        end else if (seed_load) begin
            state <= seed;
        end else if (gen_en) begin
            state   <= next_state;
            tx_bits <= next_word ^ {`PRBS_CHANNELS{tx_invert}};
        end
    end

endmodule

`default_nettype wire

// File: logic/prbs_checker_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defines.svh"

module prbs_checker_core
    import prbs_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        rx_invert,
    input  wire chk_mode_e   mode,
    input  wire prbs_state_t eqn,
    input  wire prbs_word_t  chan_sel,
    input  wire prbs_word_t  rx_bits,
    output prbs_word_t       err_word,
    output prbs_word_t       chk_mask,
    output logic             err_valid
);

    prbs_word_t                    rx_q;
    prbs_word_t                    prev_q;
    prbs_word_t                    pred;
    logic [2*`PRBS_CHANNELS-1:0]   window;
    logic                          run_q;
    logic                          run_qq;

    // first stage, capture the word and remember the one before it
    always_ff @(posedge clk) begin
        rx_q   <= rx_bits ^ {`PRBS_CHANNELS{rx_invert}};
        prev_q <= rx_q;
    end

    // run history, the word entering run only primes the window
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q  <= 1'b0;
            run_qq <= 1'b0;
        end else begin
            run_q  <= (mode == CHK_RUN);
            run_qq <= run_q;
        end
    end

    // stream order, previous word in the low half
    assign window = {rx_q, prev_q};

    // each bit predicted from the ORDER bits just before it
    always_comb begin
        for (int i = 0; i < `PRBS_CHANNELS; i++) begin
            pred[i] = 1'b0;
            for (int j = 0; j < `PRBS_ORDER; j++) begin
                pred[i] = pred[i] ^ (eqn[j] & window[`PRBS_CHANNELS + i - 1 - j]);
            end
        end
    end

    // second stage, mismatch word with the mask in force
    always_ff @(posedge clk) begin
        err_word <= rx_q ^ pred;
        chk_mask <= chan_sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_valid <= 1'b0;
        end else begin
            err_valid <= run_q && run_qq;
        end
    end

    // register block must never let the reserved mode through
    a_mode_legal: assert property (
        @(posedge clk) disable iff (rst)
        mode != chk_mode_e'(2'b11)
    ) else $error("checker mode holds the illegal encoding");

endmodule

`default_nettype wire

// File: logic/prbs_err_counter.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_err_counter
    import prbs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire chk_mode_e  mode,
    input  wire prbs_word_t err_word,
    input  wire prbs_word_t chk_mask,
    input  wire logic       err_valid,
    output count_t          err_count,
    output count_t          total_count
);

    count_t err_inc;
    count_t tot_inc;

    // only selected channels contribute
    assign err_inc = count_t'($countones(err_word & chk_mask));
    assign tot_inc = count_t'($countones(chk_mask));

    always_ff @(posedge clk) begin
        if (rst) begin
            err_count   <= '0;
            total_count <= '0;
        end else begin
            case (mode)
                CHK_CLEAR: begin
                    err_count   <= '0;
                    total_count <= '0;
                end
                CHK_RUN: begin
                    if (err_valid) begin
                        err_count   <= err_count + err_inc;
                        total_count <= total_count + tot_inc;
                    end
                end
                // freeze holds both values for software reads
                default: begin
                end
            endcase
        end
    end

    a_err_le_total: assert property (
        @(posedge clk) disable iff (rst)
        err_count <= total_count
    ) else $error("error count exceeds total count");

    // errors never grow faster than checked bits
    a_inc_bound: assert property (
        @(posedge clk) disable iff (rst)
        (mode == CHK_RUN) |=>
            ((err_count - $past(err_count)) <= (total_count - $past(total_count)))
    ) else $error("error increment larger than total increment");

endmodule

`default_nettype wire

// File: logic/prbs_bert_top.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_bert_top
    import prbs_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    input  wire prbs_word_t  rx_bits,
    output prbs_word_t       tx_bits
);

    chk_mode_e   mode;
    prbs_state_t eqn;
    prbs_state_t seed;
    prbs_word_t  chan_sel;
    logic        rx_invert;
    logic        tx_invert;
    logic        gen_en;
    logic        seed_load;
    prbs_word_t  err_word;
    prbs_word_t  chk_mask;
    logic        err_valid;
    count_t      err_count;
    count_t      total_count;

    prbs_apb_regs i_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .err_count   (err_count),
        .total_count (total_count),
        .mode        (mode),
        .eqn         (eqn),
        .seed        (seed),
        .chan_sel    (chan_sel),
        .rx_invert   (rx_invert),
        .tx_invert   (tx_invert),
        .gen_en      (gen_en),
        .seed_load   (seed_load)
    );

    prbs_generator i_gen (
        .clk       (clk),
        .rst       (rst),
        .gen_en    (gen_en),
        .seed_load (seed_load),
        .tx_invert (tx_invert),
        .seed      (seed),
        .eqn       (eqn),
        .tx_bits   (tx_bits)
    );

    prbs_checker_core i_chk (
        .clk       (clk),
        .rst       (rst),
        .rx_invert (rx_invert),
        .mode      (mode),
        .eqn       (eqn),
        .chan_sel  (chan_sel),
        .rx_bits   (rx_bits),
        .err_word  (err_word),
        .chk_mask  (chk_mask),
        .err_valid (err_valid)
    );

    prbs_err_counter i_cnt (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .err_word    (err_word),
        .chk_mask    (chk_mask),
        .err_valid   (err_valid),
        .err_count   (err_count),
        .total_count (total_count)
    );

endmodule

`default_nettype wire

// File: tb/tb_prbs_bert.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defines.svh"

module tb_prbs_bert
    import prbs_pkg::*;
();

    localparam int N           = `PRBS_CHANNELS;
    localparam int ORDER       = `PRBS_ORDER;
    localparam int MAX_DELAY   = 15;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    prbs_word_t  rx_bits;
    prbs_word_t  tx_bits;

    // copies of the configuration as written over APB
    chk_mode_e   sh_mode;
    prbs_state_t sh_eqn;
    prbs_word_t  sh_chan_sel;
    logic        sh_rx_inv;
    logic        sh_tx_inv;
    prbs_state_t gen_state;

    // loopback control
    int          loop_delay;
    logic        inj_en;

    // checker and counter model
    prbs_word_t  m_rx;
    prbs_word_t  m_prev;
    prbs_word_t  m_err;
    prbs_word_t  m_mask;
    logic        m_valid;
    logic        m_run;
    logic        m_run2;
    count_t      exp_err;
    count_t      exp_tot;
    count_t      exp_words;

    prbs_bert_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .rx_bits (rx_bits),
        .tx_bits (tx_bits)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // received word against the rule s[t] = xor of s[t-1-j] for each tap j
    function automatic prbs_word_t stream_errors(input prbs_word_t cur, input prbs_word_t prev,
                                                 input prbs_state_t taps);
        logic [2*N-1:0] s;
        prbs_word_t     e;
        logic           p;
        for (int i = 0; i < N; i++) begin
            s[i]     = prev[i];
            s[N + i] = cur[i];
        end
        for (int i = 0; i < N; i++) begin
            p = 1'b0;
            for (int j = 0; j < ORDER; j++) begin
                if (taps[j]) begin
                    p = p ^ s[N + i - 1 - j];
                end
            end
            e[i] = p ^ cur[i];
        end
        return e;
    endfunction

    task automatic model_tx_word(output prbs_word_t w);
        logic b;
        for (int i = 0; i < N; i++) begin
            b = 1'b0;
            // state bit j holds stream bit t-1-j
            for (int j = 0; j < ORDER; j++) begin
                b = b ^ (sh_eqn[j] & gen_state[j]);
            end
            w[i]      = b;
            gen_state = {gen_state[ORDER-2:0], b};
        end
        w = w ^ {N{sh_tx_inv}};
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s = %0d, expected %0d", $realtime, name, got, exp);
            report_failure("counter value wrong");
        end
    endtask

    task automatic check_word(input string name, input prbs_word_t got, input prbs_word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s = %h, expected %h", $realtime, name, got, exp);
            report_failure("word value wrong");
        end
    endtask

    task automatic check_state(input string name, input prbs_state_t got,
                               input prbs_state_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s = %h, expected %h", $realtime, name, got, exp);
            report_failure("state value wrong");
        end
    endtask

    task automatic check_mode(input string name, input chk_mode_e got, input chk_mode_e exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s = %s, expected %s", $realtime, name,
                     got.name(), exp.name());
            report_failure("checker mode wrong");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s = %b, expected %b", $realtime, name, got, exp);
            report_failure("control flag wrong");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #0.5;
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        rdata = '0;
        // setup phase on the first edge, access phase on the next
        for (int phase = 0; phase < 2; phase++) begin
            @(posedge clk);
            #0.5;
            if (phase == 0) begin
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = write;
                paddr   = addr;
                pwdata  = wdata;
            end else begin
                penable = 1'b1;
            end
        end
        // prdata is valid while the access phase lasts
        #1;
        rdata = prdata;
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
        case (addr)
            `REG_CTRL: begin
                if (data[1:0] != 2'b11) begin
                    sh_mode   = chk_mode_e'(data[1:0]);
                    sh_rx_inv = data[2];
                    sh_tx_inv = data[3];
                end
            end
            `REG_EQN:      sh_eqn      = data[ORDER-1:0];
            `REG_CHAN_SEL: sh_chan_sel = data[N-1:0];
            default: begin
            end
        endcase
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic set_ctrl(input chk_mode_e mode, input logic rx_inv, input logic tx_inv,
                            input logic gen);
        apb_write(`REG_CTRL, {27'd0, gen, tx_inv, rx_inv, mode});
    endtask

    task automatic read_counts(output count_t err, output count_t tot);
        logic [31:0] lo;
        logic [31:0] hi;
        apb_read(`REG_ERR_LO, lo);
        apb_read(`REG_ERR_HI, hi);
        err = {hi, lo};
        apb_read(`REG_TOT_LO, lo);
        apb_read(`REG_TOT_HI, hi);
        tot = {hi, lo};
    endtask

    task automatic run_loopback(input int delay, input logic inject, input int words,
                                input logic rx_inv, input logic tx_inv,
                                output count_t err, output count_t tot);
        loop_delay = delay;
        inj_en     = 1'b0;
        set_ctrl(CHK_CLEAR, rx_inv, tx_inv, 1'b1);
        // refill the delay line with the current stream
        idle_cycles(delay + 6);
        inj_en = inject;
        set_ctrl(CHK_RUN, rx_inv, tx_inv, 1'b1);
        idle_cycles(words);
        set_ctrl(CHK_FREEZE, rx_inv, tx_inv, 1'b1);
        inj_en = 1'b0;
        idle_cycles(4);
        read_counts(err, tot);
        check_count("err_count", err, exp_err);
        check_count("total_count", tot, exp_tot);
    endtask

    task automatic register_readback();
        logic [31:0] rd;
        apb_write(`REG_EQN, 32'h5a);
        apb_read(`REG_EQN, rd);
        check_state("eqn", rd[ORDER-1:0], 7'h5a);
        apb_write(`REG_CHAN_SEL, 32'ha5c3);
        apb_read(`REG_CHAN_SEL, rd);
        check_word("chan_sel", rd[N-1:0], 16'ha5c3);
        set_ctrl(CHK_FREEZE, 1'b1, 1'b0, 1'b1);
        apb_read(`REG_CTRL, rd);
        check_mode("mode", chk_mode_e'(rd[1:0]), CHK_FREEZE);
        check_flag("rx_invert", rd[2], 1'b1);
        check_flag("tx_invert", rd[3], 1'b0);
        check_flag("gen_en", rd[4], 1'b1);
        // reserved mode drops the whole write
        apb_write(`REG_CTRL, 32'h0000_000f);
        apb_read(`REG_CTRL, rd);
        check_mode("mode", chk_mode_e'(rd[1:0]), CHK_FREEZE);
        check_flag("tx_invert", rd[3], 1'b0);
        set_ctrl(CHK_CLEAR, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic generator_sequence();
        prbs_word_t exp;
        apb_write(`REG_EQN, 32'h60);
        apb_write(`REG_SEED, 32'h4b);
        gen_state = 7'h4b;
        idle_cycles(2);
        set_ctrl(CHK_CLEAR, 1'b0, 1'b0, 1'b1);
        for (int k = 0; k < 24; k++) begin
            @(posedge clk);
            #0.5;
            model_tx_word(exp);
            check_word("tx_bits", tx_bits, exp);
        end
    endtask

    task automatic clean_loopback();
        count_t err;
        count_t tot;
        int     delays [3];
        delays = '{0, 3, 11};
        apb_write(`REG_CHAN_SEL, 32'hffff);
        foreach (delays[d]) begin
            run_loopback(delays[d], 1'b0, 50, 1'b0, 1'b0, err, tot);
            check_count("err_count", err, 64'd0);
            check_count("total_count", tot, count_t'(N) * exp_words);
        end
    endtask

    task automatic error_injection();
        count_t err;
        count_t tot;
        run_loopback(7, 1'b1, 80, 1'b0, 1'b0, err, tot);
        if (err == 0) begin
            report_failure("error injection produced no counted errors");
        end
    endtask

    task automatic mask_and_inversion();
        count_t err;
        count_t tot;
        apb_write(`REG_CHAN_SEL, 32'h0f3c);
        run_loopback(2, 1'b1, 60, 1'b0, 1'b0, err, tot);
        check_count("total_count", tot, count_t'($countones(16'h0f3c)) * exp_words);
        apb_write(`REG_CHAN_SEL, 32'hffff);
        // two taps, so an inverted stream fails every prediction
        run_loopback(3, 1'b0, 40, 1'b0, 1'b1, err, tot);
        check_count("err_count", err, exp_tot);
        run_loopback(3, 1'b0, 40, 1'b1, 1'b1, err, tot);
        check_count("err_count", err, 64'd0);
    endtask

    task automatic clear_and_freeze();
        count_t err;
        count_t tot;
        count_t err2;
        count_t tot2;
        run_loopback(4, 1'b1, 40, 1'b0, 1'b0, err, tot);
        inj_en = 1'b1;
        idle_cycles(20);
        inj_en = 1'b0;
        read_counts(err2, tot2);
        check_count("err_count", err2, exp_err);
        check_count("total_count", tot2, exp_tot);
        set_ctrl(CHK_CLEAR, 1'b0, 1'b0, 1'b1);
        idle_cycles(2);
        read_counts(err2, tot2);
        check_count("err_count", err2, 64'd0);
        check_count("total_count", tot2, 64'd0);
    endtask

    // loopback from tx_bits with an optional error pattern
    initial begin : loopback
        prbs_word_t  dline [0:MAX_DELAY];
        prbs_word_t  flip;
        logic [31:0] rng;
        rng     = 32'h2a410203;
        rx_bits = '0;
        for (int k = 0; k <= MAX_DELAY; k++) begin
            dline[k] = '0;
        end
        forever begin
            @(posedge clk);
            #0.5;
            for (int k = MAX_DELAY; k > 0; k--) begin
                dline[k] = dline[k-1];
            end
            dline[0] = tx_bits;
            flip     = '0;
            if (inj_en) begin
                rng = xorshift32(rng);
                if (rng[1:0] == 2'd0) begin
                    flip = prbs_word_t'(1) << rng[7:4];
                end else if (rng[1:0] == 2'd1) begin
                    flip = rng[31:16];
                end
            end
            rx_bits = dline[loop_delay] ^ flip;
        end
    end

    // expected counts from the words that reach rx_bits
    always @(posedge clk) begin
        if (rst) begin
            exp_err   = '0;
            exp_tot   = '0;
            exp_words = '0;
            m_valid   = 1'b0;
            m_run     = 1'b0;
            m_run2    = 1'b0;
        end else begin
            if (sh_mode == CHK_CLEAR) begin
                exp_err   = '0;
                exp_tot   = '0;
                exp_words = '0;
            end else if (sh_mode == CHK_RUN && m_valid) begin
                exp_err   = exp_err + count_t'($countones(m_err & m_mask));
                exp_tot   = exp_tot + count_t'($countones(m_mask));
                exp_words = exp_words + 1;
            end
            m_err   = stream_errors(m_rx, m_prev, sh_eqn);
            m_mask  = sh_chan_sel;
            m_valid = m_run && m_run2;
            m_run2  = m_run;
            m_run   = (sh_mode == CHK_RUN);
        end
        m_prev = m_rx;
        m_rx   = rx_bits ^ {N{sh_rx_inv}};
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sh_mode     = CHK_CLEAR;
        sh_eqn      = '0;
        sh_chan_sel = '0;
        sh_rx_inv   = 1'b0;
        sh_tx_inv   = 1'b0;
        gen_state   = '0;
        loop_delay  = 0;
        inj_en      = 1'b0;
        repeat (5) begin
            @(posedge clk);
        end
        #0.5;
        rst = 1'b0;
        register_readback();
        generator_sequence();
        clean_loopback();
        error_injection();
        mask_and_inversion();
        clear_and_freeze();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/prbs_pkg.sv
logic/prbs_apb_regs.sv
logic/prbs_generator.sv
logic/prbs_checker_core.sv
logic/prbs_err_counter.sv
logic/prbs_bert_top.sv
tb/tb_prbs_bert.sv

// File: Makefile
TOP := tb_prbs_bert
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
